/* Makefile */
# Verilator flow for the data fabric: lint, simulate, clean

VERILATOR ?= verilator
TOP       ?= tb_ycr_dmem_iconnect
RTL_TOP   ?= ycr_dmem_iconnect
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* sources.f */
+incdir+src
src/ycr_dmem_pkg.sv
src/ycr_dmem_if.sv
src/ycr_dmem_decode.sv
src/ycr_timer_regs.sv
src/ycr_dmem_resp_mux.sv
src/ycr_dmem_iconnect.sv
test/ycr_dmem_checker.sv
test/tb_ycr_dmem_iconnect.sv

/* src/ycr_dmem_decode.sv */
// Address decoder and single-transaction tracker, steers the core request to timer or external port
`timescale 1ns/1ps

`include "ycr_dmem_defs.svh"

module ycr_dmem_decode
   import ycr_dmem_pkg::*;
(
   input  logic                          core_clk_i,
   input  logic                          rst_i,

   // Core request
   input  logic                          dmem_req_i,
   input  ycr_mem_cmd_e                  dmem_cmd_i,
   input  ycr_mem_width_e                dmem_width_i,
   input  logic [`YCR_DMEM_AWIDTH-1:0]   dmem_addr_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]   dmem_wdata_i,
   output logic                          dmem_req_ack_o,

   // External bus request
   output logic                          ext_req_o,
   output ycr_mem_cmd_e                  ext_cmd_o,
   output ycr_mem_width_e                ext_width_o,
   output logic [`YCR_DMEM_AWIDTH-1:0]   ext_addr_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]   ext_wdata_o,
   input  logic                          ext_req_ack_i,

   ycr_dmem_if.master                    timer_ch,

   input  logic                          resp_done_i,   // From response stage
   output ycr_dmem_tgt_e                 pend_tgt_o     // Target of the open transaction
);

   ycr_decode_state_e   state_q;
   ycr_dmem_tgt_e       tgt_sel;
   logic                idle;
   logic                sel_ack;

   //-------------------------------------------------------------------------
   // Address compare against the timer window
   //-------------------------------------------------------------------------
   assign tgt_sel = ((dmem_addr_i & `YCR_TIMER_ADDR_MASK) == `YCR_TIMER_ADDR_PATTERN) ?
                    YCR_TGT_TIMER : YCR_TGT_EXT;
   assign idle    = (state_q == YCR_DEC_IDLE);

   // Requests only leave while no transaction is open
   assign ext_req_o      = dmem_req_i & idle & (tgt_sel == YCR_TGT_EXT);
   assign timer_ch.req   = dmem_req_i & idle & (tgt_sel == YCR_TGT_TIMER);

   // Fields fan out to both targets, req picks the one that listens
   assign ext_cmd_o      = dmem_cmd_i;
   assign ext_width_o    = dmem_width_i;
   assign ext_addr_o     = dmem_addr_i;
   assign ext_wdata_o    = dmem_wdata_i;
   assign timer_ch.cmd   = dmem_cmd_i;
   assign timer_ch.width = dmem_width_i;
   assign timer_ch.addr  = dmem_addr_i;
   assign timer_ch.wdata = dmem_wdata_i;

   assign sel_ack        = (tgt_sel == YCR_TGT_TIMER) ? timer_ch.req_ack : ext_req_ack_i;
   assign dmem_req_ack_o = dmem_req_i & idle & sel_ack;   // Accept strobe toward core

   //-------------------------------------------------------------------------
   // Idle / wait FSM and pending target
   //-------------------------------------------------------------------------
   always_ff @(posedge core_clk_i) begin
      if (rst_i) begin
         state_q    <= YCR_DEC_IDLE;
         pend_tgt_o <= YCR_TGT_EXT;
      end else begin
         case (state_q)
            YCR_DEC_IDLE: begin
               if (dmem_req_ack_o) begin
                  state_q    <= YCR_DEC_WAIT;
                  pend_tgt_o <= tgt_sel;              // Response stage follows this
               end
            end
            default: begin
               if (resp_done_i) state_q <= YCR_DEC_IDLE;
            end
         endcase
      end
   end

endmodule : ycr_dmem_decode

/* src/ycr_dmem_defs.svh */
// Bus widths and timer address window of the data fabric, included by the package and RTL

`ifndef YCR_DMEM_DEFS_SVH
`define YCR_DMEM_DEFS_SVH

//--------------------------------------------------------------------------
// Core data port widths
//--------------------------------------------------------------------------
`define YCR_DMEM_AWIDTH          32               // Byte address
`define YCR_DMEM_DWIDTH          32               // Data word

//--------------------------------------------------------------------------
// Machine timer
//--------------------------------------------------------------------------
`define YCR_TIMER_WIDTH          64               // mtime and mtimecmp

// Timer window, 32 bytes starting at the base
// Eight word slots, offset taken from address bits 4:2
`define YCR_TIMER_ADDR_PATTERN   32'hF004_0000
`define YCR_TIMER_ADDR_MASK      32'hFFFF_FFE0

// Anything outside the window is routed to the external port

`endif

/* src/ycr_dmem_iconnect.sv */
// Data-side fabric top, joins decoder, timer block and response stage to core and external ports
`timescale 1ns/1ps

`include "ycr_dmem_defs.svh"

module ycr_dmem_iconnect
   import ycr_dmem_pkg::*;
(
   input  logic                          core_clk_i,
   input  logic                          rst_i,

   // Core data port
   input  logic                          dmem_req_i,
   input  ycr_mem_cmd_e                  dmem_cmd_i,
   input  ycr_mem_width_e                dmem_width_i,
   input  logic [`YCR_DMEM_AWIDTH-1:0]   dmem_addr_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]   dmem_wdata_i,
   output logic                          dmem_req_ack_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]   dmem_rdata_o,
   output ycr_mem_resp_e                 dmem_resp_o,

   // External bus port, toward the system bus bridge
   output logic                          ext_req_o,
   output ycr_mem_cmd_e                  ext_cmd_o,
   output ycr_mem_width_e                ext_width_o,
   output logic [`YCR_DMEM_AWIDTH-1:0]   ext_addr_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]   ext_wdata_o,
   input  logic                          ext_req_ack_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]   ext_rdata_i,
   input  ycr_mem_resp_e                 ext_resp_i,

   // Timer and config side outputs
   output logic [`YCR_TIMER_WIDTH-1:0]   timer_val_o,
   output logic                          timer_irq_o,
   output logic                          dcache_force_flush_o
);

   ycr_dmem_tgt_e   pend_tgt;
   logic            resp_done;

   ycr_dmem_if timer_ch ();                       // Decoder to timer block

   //-------------------------------------------------------------------------
   // Request routing
   //-------------------------------------------------------------------------
   ycr_dmem_decode u_decode (
      .core_clk_i     (core_clk_i    ),
      .rst_i          (rst_i         ),
      .dmem_req_i     (dmem_req_i    ),
      .dmem_cmd_i     (dmem_cmd_i    ),
      .dmem_width_i   (dmem_width_i  ),
      .dmem_addr_i    (dmem_addr_i   ),
      .dmem_wdata_i   (dmem_wdata_i  ),
      .dmem_req_ack_o (dmem_req_ack_o),
      .ext_req_o      (ext_req_o     ),
      .ext_cmd_o      (ext_cmd_o     ),
      .ext_width_o    (ext_width_o   ),
      .ext_addr_o     (ext_addr_o    ),
      .ext_wdata_o    (ext_wdata_o   ),
      .ext_req_ack_i  (ext_req_ack_i ),
      .timer_ch       (timer_ch      ),
      .resp_done_i    (resp_done     ),
      .pend_tgt_o     (pend_tgt      )
   );

   ycr_timer_regs u_timer (
      .core_clk_i           (core_clk_i          ),
      .rst_i                (rst_i               ),
      .timer_ch             (timer_ch            ),
      .timer_val_o          (timer_val_o         ),
      .timer_irq_o          (timer_irq_o         ),
      .dcache_force_flush_o (dcache_force_flush_o)
   );

   // Return path
   ycr_dmem_resp_mux u_resp_mux (
      .core_clk_i   (core_clk_i  ),
      .rst_i        (rst_i       ),
      .pend_tgt_i   (pend_tgt    ),
      .timer_ch     (timer_ch    ),
      .ext_rdata_i  (ext_rdata_i ),
      .ext_resp_i   (ext_resp_i  ),
      .dmem_rdata_o (dmem_rdata_o),
      .dmem_resp_o  (dmem_resp_o ),
      .resp_done_o  (resp_done   )
   );

endmodule : ycr_dmem_iconnect

/* src/ycr_dmem_if.sv */
// One request/response memory channel between fabric blocks, with master, slave and monitor views
`timescale 1ns/1ps

`include "ycr_dmem_defs.svh"

interface ycr_dmem_if
   import ycr_dmem_pkg::*;
();

   // Request side, held stable until req and req_ack meet
   logic                          req;
   ycr_mem_cmd_e                  cmd;
   ycr_mem_width_e                width;
   logic [`YCR_DMEM_AWIDTH-1:0]   addr;
   logic [`YCR_DMEM_DWIDTH-1:0]   wdata;

   // Slave answers
   logic                          req_ack;        // Accept strobe
   logic [`YCR_DMEM_DWIDTH-1:0]   rdata;          // Valid with resp
   ycr_mem_resp_e                 resp;           // One cycle not idle

   modport master (
      output req, cmd, width, addr, wdata,
      input  req_ack, rdata, resp
   );

   modport slave (
      input  req, cmd, width, addr, wdata,
      output req_ack, rdata, resp
   );

   modport monitor (input rdata, resp);           // Response stage only

endinterface : ycr_dmem_if

/* src/ycr_dmem_pkg.sv */
// Shared enum types of the data fabric, imported by the interface and every RTL module

`include "ycr_dmem_defs.svh"

package ycr_dmem_pkg;

   // Memory protocol encodings
   typedef enum logic {
      YCR_MEM_CMD_RD = 1'b0,
      YCR_MEM_CMD_WR = 1'b1
   } ycr_mem_cmd_e;

   typedef enum logic [1:0] {
      YCR_MEM_WIDTH_BYTE  = 2'b00,
      YCR_MEM_WIDTH_HWORD = 2'b01,
      YCR_MEM_WIDTH_WORD  = 2'b10
   } ycr_mem_width_e;

   typedef enum logic [1:0] {
      YCR_MEM_RESP_NOTRDY = 2'b00,                // Idle, no response this cycle
      YCR_MEM_RESP_RDY_OK = 2'b01,
      YCR_MEM_RESP_RDY_ER = 2'b10
   } ycr_mem_resp_e;

   typedef enum logic {YCR_TGT_EXT, YCR_TGT_TIMER} ycr_dmem_tgt_e;
   typedef enum logic {YCR_DEC_IDLE, YCR_DEC_WAIT} ycr_decode_state_e;

   // Timer word offsets, addr[4:2]
   typedef enum logic [2:0] {
      YCR_TMR_CTRL       = 3'd0,                  // Bit 0 count enable
      YCR_TMR_MTIMELO    = 3'd2,
      YCR_TMR_MTIMEHI    = 3'd3,
      YCR_TMR_MTIMECMPLO = 3'd4,
      YCR_TMR_MTIMECMPHI = 3'd5,
      YCR_TMR_GLBL_CFG   = 3'd6
   } ycr_timer_reg_e;

endpackage : ycr_dmem_pkg

/* src/ycr_dmem_resp_mux.sv */
// Response selector for the open transaction, registers rdata and resp back to the core
`timescale 1ns/1ps

`include "ycr_dmem_defs.svh"

module ycr_dmem_resp_mux
   import ycr_dmem_pkg::*;
(
   input  logic                          core_clk_i,
   input  logic                          rst_i,

   input  ycr_dmem_tgt_e                 pend_tgt_i,
   ycr_dmem_if.monitor                   timer_ch,
   input  logic [`YCR_DMEM_DWIDTH-1:0]   ext_rdata_i,
   input  ycr_mem_resp_e                 ext_resp_i,

   output logic [`YCR_DMEM_DWIDTH-1:0]   dmem_rdata_o,
   output ycr_mem_resp_e                 dmem_resp_o,
   output logic                          resp_done_o    // Pulse to the decoder
);

   logic [`YCR_DMEM_DWIDTH-1:0]   sel_rdata;
   ycr_mem_resp_e                 sel_resp;

   // Only the pending target is listened to
   assign sel_rdata   = (pend_tgt_i == YCR_TGT_TIMER) ? timer_ch.rdata : ext_rdata_i;
   assign sel_resp    = (pend_tgt_i == YCR_TGT_TIMER) ? timer_ch.resp  : ext_resp_i;
   assign resp_done_o = (sel_resp != YCR_MEM_RESP_NOTRDY);

   //-------------------------------------------------------------------------
   // Return register, one cycle behind the target
   //-------------------------------------------------------------------------
   always_ff @(posedge core_clk_i) begin
      if (rst_i) dmem_resp_o <= YCR_MEM_RESP_NOTRDY;
      else       dmem_resp_o <= resp_done_o ? sel_resp : YCR_MEM_RESP_NOTRDY;
   end

   always_ff @(posedge core_clk_i) begin
      if (resp_done_o) dmem_rdata_o <= sel_rdata;   // Held until next response
   end

endmodule : ycr_dmem_resp_mux

/* src/ycr_timer_regs.sv */
// Memory-mapped machine timer with compare interrupt, control and global configuration registers
`timescale 1ns/1ps

`include "ycr_dmem_defs.svh"

module ycr_timer_regs
   import ycr_dmem_pkg::*;
(
   input  logic                          core_clk_i,
   input  logic                          rst_i,

   ycr_dmem_if.slave                     timer_ch,

   output logic [`YCR_TIMER_WIDTH-1:0]   timer_val_o,          // mtime
   output logic                          timer_irq_o,
   output logic                          dcache_force_flush_o  // glbl_cfg[0]
);

   logic                          acc;
   logic                          word_ok;
   logic                          wr;
   ycr_timer_reg_e                reg_off;

   logic                          ctrl_en_q;                  // Count enable
   logic [`YCR_TIMER_WIDTH-1:0]   mtime_q;
   logic [`YCR_TIMER_WIDTH-1:0]   mtime_nxt;
   logic [`YCR_TIMER_WIDTH-1:0]   mtimecmp_q;
   logic [`YCR_DMEM_DWIDTH-1:0]   glbl_cfg_q;
   logic [`YCR_DMEM_DWIDTH-1:0]   rdata_nxt;

   //-------------------------------------------------------------------------
   // Bus access decode
   //-------------------------------------------------------------------------
   assign timer_ch.req_ack = timer_ch.req;                    // Always ready
   assign acc              = timer_ch.req;
   assign word_ok          = (timer_ch.width == YCR_MEM_WIDTH_WORD);
   assign wr               = acc & word_ok & (timer_ch.cmd == YCR_MEM_CMD_WR);
   assign reg_off          = ycr_timer_reg_e'(timer_ch.addr[4:2]);

   // Counter step, then a write replaces one half
   always_comb begin
      mtime_nxt = ctrl_en_q ? mtime_q + 1'b1 : mtime_q;
      if (wr && reg_off == YCR_TMR_MTIMELO) mtime_nxt[31:0]  = timer_ch.wdata;
      if (wr && reg_off == YCR_TMR_MTIMEHI) mtime_nxt[63:32] = timer_ch.wdata;
   end

   // Read data select
   always_comb begin
      case (reg_off)
         YCR_TMR_CTRL:       rdata_nxt = {31'b0, ctrl_en_q};
         YCR_TMR_MTIMELO:    rdata_nxt = mtime_q[31:0];
         YCR_TMR_MTIMEHI:    rdata_nxt = mtime_q[63:32];
         YCR_TMR_MTIMECMPLO: rdata_nxt = mtimecmp_q[31:0];
         YCR_TMR_MTIMECMPHI: rdata_nxt = mtimecmp_q[63:32];
         YCR_TMR_GLBL_CFG:   rdata_nxt = glbl_cfg_q;
         default:            rdata_nxt = '0;            // Unmapped slot
      endcase
      if (!word_ok) rdata_nxt = '0;
   end

   //-------------------------------------------------------------------------
   // Register file
   //-------------------------------------------------------------------------
   always_ff @(posedge core_clk_i) begin
      if (rst_i) begin
         ctrl_en_q  <= 1'b0;
         mtime_q    <= '0;
         mtimecmp_q <= '1;                                  // No interrupt out of reset
         glbl_cfg_q <= '0;
      end else begin
         mtime_q <= mtime_nxt;
         if (wr) begin
            case (reg_off)
               YCR_TMR_CTRL:       ctrl_en_q          <= timer_ch.wdata[0];
               YCR_TMR_MTIMECMPLO: mtimecmp_q[31:0]   <= timer_ch.wdata;
               YCR_TMR_MTIMECMPHI: mtimecmp_q[63:32]  <= timer_ch.wdata;
               YCR_TMR_GLBL_CFG:   glbl_cfg_q         <= timer_ch.wdata;
               default: ;                                   // mtime handled above
            endcase
         end
      end
   end

   // Response one cycle after acceptance
   always_ff @(posedge core_clk_i) begin
      if (rst_i) begin
         timer_ch.resp <= YCR_MEM_RESP_NOTRDY;
         timer_irq_o   <= 1'b0;
      end else begin
         if (acc) timer_ch.resp <= word_ok ? YCR_MEM_RESP_RDY_OK : YCR_MEM_RESP_RDY_ER;
         else     timer_ch.resp <= YCR_MEM_RESP_NOTRDY;
         timer_irq_o <= (mtime_q >= mtimecmp_q);            // Level, follows compare
      end
   end

   always_ff @(posedge core_clk_i) begin
      if (acc) timer_ch.rdata <= rdata_nxt;
   end

   assign timer_val_o          = mtime_q;
   assign dcache_force_flush_o = glbl_cfg_q[0];

endmodule : ycr_timer_regs

/* test/tb_ycr_dmem_iconnect.sv */
// Table-driven testbench that runs core accesses on the data fabric top against an external memory
`timescale 1ns/1ps

`include "ycr_dmem_defs.svh"

module tb_ycr_dmem_iconnect
   import ycr_dmem_pkg::*;
();

   typedef enum logic [2:0] {
      CHK_NONE, CHK_DATA, CHK_FLUSH, CHK_IRQ, CHK_SAMPLE, CHK_INC, CHK_MTIME
   } check_e;

   typedef struct packed {
      ycr_mem_cmd_e     cmd;
      ycr_mem_width_e   width;
      logic [31:0]      addr;
      logic [31:0]      wdata;
      ycr_mem_resp_e    exp_resp;
      logic [31:0]      exp_rdata;                   // Also expected level for flush / irq
      check_e           chk;
   } row_t;

   // Short names keep the table readable
   localparam ycr_mem_cmd_e   RD = YCR_MEM_CMD_RD;
   localparam ycr_mem_cmd_e   WR = YCR_MEM_CMD_WR;
   localparam ycr_mem_width_e W  = YCR_MEM_WIDTH_WORD;
   localparam ycr_mem_width_e H  = YCR_MEM_WIDTH_HWORD;
   localparam ycr_mem_resp_e  OK = YCR_MEM_RESP_RDY_OK;
   localparam ycr_mem_resp_e  ER = YCR_MEM_RESP_RDY_ER;

   // Timer window slots
   localparam logic [31:0] T_CTRL  = `YCR_TIMER_ADDR_PATTERN + 32'h00;
   localparam logic [31:0] T_MTLO  = `YCR_TIMER_ADDR_PATTERN + 32'h08;
   localparam logic [31:0] T_MTHI  = `YCR_TIMER_ADDR_PATTERN + 32'h0C;
   localparam logic [31:0] T_CMPLO = `YCR_TIMER_ADDR_PATTERN + 32'h10;
   localparam logic [31:0] T_CMPHI = `YCR_TIMER_ADDR_PATTERN + 32'h14;
   localparam logic [31:0] T_CFG   = `YCR_TIMER_ADDR_PATTERN + 32'h18;

   logic             core_clk_i;
   logic             rst_i;
   logic             dmem_req_i;
   ycr_mem_cmd_e     dmem_cmd_i;
   ycr_mem_width_e   dmem_width_i;
   logic [31:0]      dmem_addr_i;
   logic [31:0]      dmem_wdata_i;
   logic             dmem_req_ack_o;
   logic [31:0]      dmem_rdata_o;
   ycr_mem_resp_e    dmem_resp_o;
   logic             ext_req_o;
   ycr_mem_cmd_e     ext_cmd_o;
   ycr_mem_width_e   ext_width_o;
   logic [31:0]      ext_addr_o;
   logic [31:0]      ext_wdata_o;
   logic             ext_req_ack_i;
   logic [31:0]      ext_rdata_i;
   ycr_mem_resp_e    ext_resp_i;
   logic [63:0]      timer_val_o;
   logic             timer_irq_o;
   logic             dcache_force_flush_o;

   row_t             tbl [$];
   logic [31:0]      ext_mem [16];                   // External memory model
   logic [31:0]      cur_addr;                       // Address of the row in flight
   logic [31:0]      mtime_prev;
   int               max_cycles = 0;
   int               cycle_cnt;

   ycr_dmem_iconnect ycr_dmem_iconnect_i (.*);

   task automatic fail_now(input string msg);
      $display("error: t=%0t %s", $time, msg);
      $display("Something failed");
      $fatal(1, "stopped on first error");
   endtask

   function automatic void add_row(input ycr_mem_cmd_e c, input ycr_mem_width_e w,
                                   input logic [31:0] a, input logic [31:0] d,
                                   input ycr_mem_resp_e er, input logic [31:0] ed,
                                   input check_e k);
      row_t r;
      r = '{c, w, a, d, er, ed, k};
      tbl.push_back(r);
   endfunction

   //--------------------------------------------------------------------------
   // Stimulus table columns cmd, width, addr, wdata, resp, rdata or level, check
   //--------------------------------------------------------------------------
   task automatic load_table();
      add_row(WR, W, 32'h0000_1000, 32'h1111_2222, OK, 32'h0,          CHK_NONE);
      add_row(WR, W, 32'h0000_1024, 32'hA5A5_0F0F, OK, 32'h0,          CHK_NONE);
      add_row(WR, W, 32'h0000_103C, 32'hDEAD_BEEF, OK, 32'h0,          CHK_NONE);
      add_row(RD, W, 32'h0000_1000, 32'h0,         OK, 32'h1111_2222,  CHK_DATA);
      add_row(RD, W, 32'h0000_1024, 32'h0,         OK, 32'hA5A5_0F0F,  CHK_DATA);
      add_row(RD, W, 32'h0000_103C, 32'h0,         OK, 32'hDEAD_BEEF,  CHK_DATA);
      add_row(WR, W, T_MTLO,        32'h0000_0100, OK, 32'h0,          CHK_NONE);  // Count off
      add_row(WR, W, T_MTHI,        32'h0000_0002, OK, 32'h0,          CHK_NONE);
      add_row(RD, W, T_MTLO,        32'h0,         OK, 32'h0000_0100,  CHK_MTIME);
      add_row(RD, W, T_MTHI,        32'h0,         OK, 32'h0000_0002,  CHK_MTIME);
      add_row(WR, W, T_CFG,         32'h0000_0001, OK, 32'h1,          CHK_FLUSH);
      add_row(RD, W, T_CFG,         32'h0,         OK, 32'h0000_0001,  CHK_DATA);
      add_row(WR, W, T_CFG,         32'h0000_00F0, OK, 32'h0,          CHK_FLUSH);
      add_row(RD, W, T_CFG,         32'h0,         OK, 32'h0000_00F0,  CHK_DATA);
      add_row(WR, H, T_MTLO,        32'h0000_FFFF, ER, 32'h0,          CHK_NONE);  // Not word wide
      add_row(RD, W, T_MTLO,        32'h0,         OK, 32'h0000_0100,  CHK_MTIME);
      add_row(WR, W, T_CMPLO,       32'h0000_0050, OK, 32'h0,          CHK_NONE);
      add_row(WR, W, T_CMPHI,       32'h0,         OK, 32'h1,          CHK_IRQ);
      add_row(WR, W, T_CMPLO,       32'hFFFF_FFFF, OK, 32'h0,          CHK_NONE);
      add_row(WR, W, T_CMPHI,       32'hFFFF_FFFF, OK, 32'h0,          CHK_IRQ);
      add_row(WR, W, T_CTRL,        32'h0000_0001, OK, 32'h0,          CHK_NONE);  // Count on
      add_row(RD, W, T_CTRL,        32'h0,         OK, 32'h0000_0001,  CHK_DATA);
      add_row(RD, W, T_MTLO,        32'h0,         OK, 32'h0,          CHK_SAMPLE);
      add_row(RD, W, T_MTLO,        32'h0,         OK, 32'h0,          CHK_INC);
   endtask

   // One core access holds req until accepted and then waits for the response
   task automatic run_row(input int n);
      row_t        r;
      int          wait_cyc;
      logic [31:0] tval_half;
      r = tbl[n];
      @(posedge core_clk_i);
      #1;
      dmem_req_i   = 1'b1;
      dmem_cmd_i   = r.cmd;
      dmem_width_i = r.width;
      dmem_addr_i  = r.addr;
      dmem_wdata_i = r.wdata;
      cur_addr     = r.addr;
      @(negedge core_clk_i);
      while (!dmem_req_ack_o) @(negedge core_clk_i);
      @(posedge core_clk_i);                         // Accept edge
      #1;
      dmem_req_i = 1'b0;
      @(negedge core_clk_i);
      while (dmem_resp_o == YCR_MEM_RESP_NOTRDY) @(negedge core_clk_i);
      assert (dmem_resp_o == r.exp_resp)
         else fail_now($sformatf("row %0d resp %s, expected %s", n,
                                 dmem_resp_o.name(), r.exp_resp.name()));
      case (r.chk)
         CHK_DATA:
            assert (dmem_rdata_o == r.exp_rdata)
               else fail_now($sformatf("row %0d rdata %h, expected %h", n, dmem_rdata_o,
                                       r.exp_rdata));
         CHK_MTIME: begin
            // Counter is stopped, so the timer output half must match the readback
            tval_half = r.addr[2] ? timer_val_o[63:32] : timer_val_o[31:0];
            assert (dmem_rdata_o == r.exp_rdata && tval_half == r.exp_rdata)
               else fail_now($sformatf("row %0d rdata %h timer_val_o %h, expected %h", n,
                                       dmem_rdata_o, timer_val_o, r.exp_rdata));
         end
         CHK_FLUSH:
            assert (dcache_force_flush_o == r.exp_rdata[0])
               else fail_now($sformatf("row %0d flush %b, expected %b", n,
                                       dcache_force_flush_o, r.exp_rdata[0]));
         CHK_IRQ: begin
            wait_cyc = 0;
            while (timer_irq_o != r.exp_rdata[0] && wait_cyc < 2) begin
               @(negedge core_clk_i);
               wait_cyc++;
            end
            assert (timer_irq_o == r.exp_rdata[0])
               else fail_now($sformatf("row %0d irq %b, expected %b", n, timer_irq_o,
                                       r.exp_rdata[0]));
         end
         CHK_SAMPLE: mtime_prev = dmem_rdata_o;
         CHK_INC:
            assert (dmem_rdata_o > mtime_prev)
               else fail_now($sformatf("row %0d mtime %h not above %h", n, dmem_rdata_o,
                                       mtime_prev));
         default: ;
      endcase
   endtask

   initial begin : clk_gen
      core_clk_i = 1'b0;
      forever #5 core_clk_i = ~core_clk_i;
   end

   //--------------------------------------------------------------------------
   // External memory model with random accept and response latency
   //--------------------------------------------------------------------------
   initial begin : ext_model
      int unsigned ack_dly;
      int unsigned rsp_dly;
      logic [3:0]  idx;
      ext_req_ack_i = 1'b0;
      ext_rdata_i   = '0;
      ext_resp_i    = YCR_MEM_RESP_NOTRDY;
      foreach (ext_mem[i]) ext_mem[i] = 32'hC0DE_0000 + 32'(i);
      void'($urandom(32'h5351fe6b));
      forever begin
         @(negedge core_clk_i);
         if (ext_req_o) begin
            ack_dly = $urandom_range(3, 0);
            rsp_dly = $urandom_range(1, 0);
            repeat (ack_dly) @(posedge core_clk_i);
            @(posedge core_clk_i);
            #1;
            ext_req_ack_i = 1'b1;
            @(negedge core_clk_i);                   // Accepted on the next edge
            assert (ext_addr_o == cur_addr)
               else fail_now($sformatf("ext_addr_o %h, expected %h", ext_addr_o, cur_addr));
            idx = ext_addr_o[5:2];
            if (ext_cmd_o == YCR_MEM_CMD_WR) ext_mem[idx] = ext_wdata_o;
            @(posedge core_clk_i);
            #1;
            ext_req_ack_i = 1'b0;
            repeat (rsp_dly) begin
               @(posedge core_clk_i);
               #1;
            end
            ext_resp_i  = YCR_MEM_RESP_RDY_OK;
            ext_rdata_i = ext_mem[idx];
            @(posedge core_clk_i);
            #1;
            ext_resp_i  = YCR_MEM_RESP_NOTRDY;
            ext_rdata_i = '0;
         end
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      wait (max_cycles != 0);
      while (cycle_cnt < max_cycles) begin
         @(posedge core_clk_i);
         cycle_cnt++;
      end
      $display("Timeout: the test did not finish within %0d cycles", max_cycles);
      $display("Something failed");
      $fatal(1, "watchdog expired");
   end

   initial begin : main
      rst_i        = 1'b1;
      dmem_req_i   = 1'b0;
      dmem_cmd_i   = YCR_MEM_CMD_RD;
      dmem_width_i = YCR_MEM_WIDTH_WORD;
      dmem_addr_i  = '0;
      dmem_wdata_i = '0;
      cur_addr     = '0;
      mtime_prev   = '0;
      load_table();
      max_cycles = tbl.size() * 40 + 100;            // Up to 7 cycles per row plus margin
      repeat (3) @(posedge core_clk_i);
      #1;
      rst_i = 1'b0;
      @(negedge core_clk_i);
      assert (!dmem_req_ack_o && !ext_req_o && dmem_resp_o == YCR_MEM_RESP_NOTRDY &&
              !timer_irq_o && !dcache_force_flush_o)
         else fail_now("outputs not inactive after reset");
      foreach (tbl[i]) run_row(i);
      repeat (2) @(posedge core_clk_i);
      if (ycr_dmem_iconnect_i.u_checker.viol_cnt == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("Something failed");
         $fatal(1, "protocol checker saw %0d violations", ycr_dmem_iconnect_i.u_checker.viol_cnt);
      end
   end

endmodule : tb_ycr_dmem_iconnect

/* test/ycr_dmem_checker.sv */
// Protocol assertions on the core data port, bound into the fabric top level
`timescale 1ns/1ps

module ycr_dmem_checker
   import ycr_dmem_pkg::*;
(
   input  logic            core_clk_i,
   input  logic            rst_i,
   input  logic            dmem_req_i,
   input  logic            dmem_req_ack_o,
   input  ycr_mem_resp_e   dmem_resp_o
);

   int     viol_cnt = 0;                           // Read by the testbench at the end
   logic   open_q;                                 // Accepted, response not yet back

   always_ff @(posedge core_clk_i) begin
      if (rst_i)                                     open_q <= 1'b0;
      else if (dmem_req_ack_o)                       open_q <= 1'b1;
      else if (dmem_resp_o != YCR_MEM_RESP_NOTRDY)   open_q <= 1'b0;
   end

   //--------------------------------------------------------------------------
   // Core port rules
   //--------------------------------------------------------------------------
   ack_needs_req: assert property (@(posedge core_clk_i) disable iff (rst_i)
      dmem_req_ack_o |-> dmem_req_i)
      else begin
         viol_cnt++;
         $error("acknowledge without a request");
      end

   resp_one_cycle: assert property (@(posedge core_clk_i) disable iff (rst_i)
      (dmem_resp_o != YCR_MEM_RESP_NOTRDY) |=> (dmem_resp_o == YCR_MEM_RESP_NOTRDY))
      else begin
         viol_cnt++;
         $error("response held longer than one cycle");
      end

   // Single outstanding transaction
   no_ack_while_open: assert property (@(posedge core_clk_i) disable iff (rst_i)
      (open_q && dmem_resp_o == YCR_MEM_RESP_NOTRDY) |-> !dmem_req_ack_o)
      else begin
         viol_cnt++;
         $error("second acknowledge before the response returned");
      end

endmodule : ycr_dmem_checker

bind ycr_dmem_iconnect ycr_dmem_checker u_checker (
   .core_clk_i     (core_clk_i    ),
   .rst_i          (rst_i         ),
   .dmem_req_i     (dmem_req_i    ),
   .dmem_req_ack_o (dmem_req_ack_o),
   .dmem_resp_o    (dmem_resp_o   )
);
